/* rtl/lsPkg.sv */
package lsPkg;

    localparam int DataWidth  = 32;
    localparam int TagWidth   = 4;
    localparam int AddrWidth  = 6;
    localparam int LsDepth    = 4;                    // Queue entries and reset credits
    localparam int MemLatency = 3;                    // Cycles spent in ACCESS
    localparam int MemWords   = 64;
    localparam int PtrWidth   = $clog2(LsDepth);
    localparam int CntWidth   = $clog2(MemLatency + 1);

    typedef logic [DataWidth-1:0] dataT;
    typedef logic [TagWidth-1:0]  tagT;
    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [PtrWidth-1:0]  ptrT;
    typedef logic [CntWidth-1:0]  cntT;

    // Either a value, or the tag it is waiting for
    typedef struct packed {
        logic ready;
        tagT  tag;
        dataT value;
    } lsOperandT;

    typedef struct packed {
        logic      isStore;
        lsOperandT base;
        lsOperandT storeData;                         // Ignored by loads
        dataT      imm;
        tagT       dstTag;
    } lsDispatchT;

    typedef struct packed {
        logic valid;
        tagT  tag;
        dataT data;
    } resultBusT;

    typedef struct packed {
        logic isStore;
        addrT addr;
        dataT data;
        tagT  dstTag;
    } memReqT;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        FINISH
    } ctrlStateT;

endpackage

/* rtl/accessTimer.sv */
module accessTimer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic expired
);
    import lsPkg::*;

    cntT  count;
    logic active;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count  <= '0;
            active <= 1'b0;
        end else if (start) begin
            count  <= cntT'(MemLatency - 1);
            active <= 1'b1;
        end else if (active) begin
            if (count == '0)
                active <= 1'b0;
            else
                count <= count - 1'b1;
        end
    end

    assign expired = active && (count == '0);  // Last ACCESS cycle

endmodule

/* rtl/dataMem.sv */
module dataMem (
    input  logic        clk,
    input  logic        write,
    input  lsPkg::addrT addr,
    input  lsPkg::dataT wData,
    output lsPkg::dataT rData
);
    import lsPkg::*;

    dataT mem [MemWords];

    always_ff @(posedge clk) begin
        if (write)
            mem[addr] <= wData;
        rData <= mem[addr];                   // One cycle after the address
    end

endmodule

/* rtl/lsEntry.sv */
module lsEntry (
    input  logic              clk,
    input  logic              rst,
    input  logic              write,
    input  lsPkg::lsDispatchT writeData,
    input  lsPkg::resultBusT  aluResult,
    input  lsPkg::resultBusT  loadResult,
    input  logic              free,
    input  logic              markIssued,
    output logic              occupied,
    output logic              ready,
    output logic              issued,
    output lsPkg::lsDispatchT entry
);
    import lsPkg::*;

    // Capture a broadcast whose tag this operand is waiting for
    function automatic lsOperandT wake(lsOperandT op, resultBusT alu, resultBusT ld);
        lsOperandT res;
        res = op;
        if (!op.ready && alu.valid && alu.tag == op.tag) begin
            res.ready = 1'b1;
            res.value = alu.data;
        end else if (!op.ready && ld.valid && ld.tag == op.tag) begin
            res.ready = 1'b1;
            res.value = ld.data;
        end
        return res;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            occupied <= 1'b0;
            issued   <= 1'b0;
        end else begin
            if (free) begin
                occupied <= 1'b0;
                issued   <= 1'b0;
            end
            if (markIssued)
                issued <= 1'b1;
            if (write) begin
                occupied <= 1'b1;
                issued   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            entry           <= writeData;
            entry.base      <= wake(writeData.base, aluResult, loadResult);  // Same-cycle wakeup
            entry.storeData <= wake(writeData.storeData, aluResult, loadResult);
        end else begin
            entry.base      <= wake(entry.base, aluResult, loadResult);
            entry.storeData <= wake(entry.storeData, aluResult, loadResult);
        end
    end

    assign ready = occupied && entry.base.ready && (entry.storeData.ready || !entry.isStore);

endmodule

/* rtl/lsQueue.sv */
module lsQueue (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispatchValid,
    input  lsPkg::lsDispatchT dispatch,
    input  lsPkg::resultBusT  aluResult,
    input  lsPkg::resultBusT  loadResult,
    input  logic              ctrlIdle,
    input  logic              accessDone,
    output logic              issueValid,
    output lsPkg::memReqT     issueReq,
    output logic              creditReturn
);
    import lsPkg::*;

    ptrT              head;
    ptrT              tail;
    logic [LsDepth-1:0] writeVec;
    logic [LsDepth-1:0] freeVec;
    logic [LsDepth-1:0] issueVec;
    logic [LsDepth-1:0] occupied;
    logic [LsDepth-1:0] ready;
    logic [LsDepth-1:0] issued;
    lsDispatchT       entries [LsDepth];
    lsDispatchT       headEntry;
    dataT             effAddr;

    genvar i;
    generate
        for (i = 0; i < LsDepth; i++) begin : gEntry
            lsEntry uEntry (
                .clk        (clk),
                .rst        (rst),
                .write      (writeVec[i]),
                .writeData  (dispatch),
                .aluResult  (aluResult),
                .loadResult (loadResult),
                .free       (freeVec[i]),
                .markIssued (issueVec[i]),
                .occupied   (occupied[i]),
                .ready      (ready[i]),
                .issued     (issued[i]),
                .entry      (entries[i])
            );
        end
    endgenerate

    // Tail and head decode
    always_comb begin
        writeVec       = '0;
        freeVec        = '0;
        issueVec       = '0;
        writeVec[tail] = dispatchValid;
        freeVec[head]  = accessDone;
        issueVec[head] = issueValid && ctrlIdle;
    end

    assign headEntry  = entries[head];
    assign issueValid = ready[head] && !issued[head];  // Only the head may issue
    assign effAddr    = headEntry.base.value + headEntry.imm;

    always_comb begin
        issueReq.isStore = headEntry.isStore;
        issueReq.addr    = effAddr[AddrWidth-1:0];
        issueReq.data    = headEntry.storeData.value;
        issueReq.dstTag  = headEntry.dstTag;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            creditReturn <= 1'b0;
        end else begin
            if (dispatchValid)
                tail <= ptrT'(tail + 1'b1);
            if (accessDone)
                head <= ptrT'(head + 1'b1);
            creditReturn <= accessDone;            // Edge after FINISH
        end
    end

    noDispatchWhenFull: assert property (
        @(posedge clk) disable iff (rst)
        dispatchValid |-> !(&occupied)
    );

    doneNeedsIssuedHead: assert property (
        @(posedge clk) disable iff (rst)
        accessDone |-> (occupied[head] && issued[head])
    );

endmodule

/* rtl/memCtrl.sv */
module memCtrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             issueValid,
    input  lsPkg::memReqT    issueReq,
    input  logic             timerExpired,
    input  lsPkg::dataT      memRData,
    output logic             ctrlIdle,
    output logic             accessDone,
    output logic             timerStart,
    output logic             memWrite,
    output lsPkg::addrT      memAddr,
    output lsPkg::dataT      memWData,
    output lsPkg::resultBusT loadResult
);
    import lsPkg::*;

    ctrlStateT state;
    memReqT    req;

    assign ctrlIdle   = (state == IDLE);
    assign timerStart = ctrlIdle && issueValid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (issueValid) state <= ACCESS;
                ACCESS:  if (timerExpired) state <= FINISH;
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (timerStart)
            req <= issueReq;                       // Held for the whole access
    end

    assign accessDone      = (state == FINISH);
    assign memWrite        = accessDone && req.isStore;
    assign memAddr         = req.addr;
    assign memWData        = req.data;
    assign loadResult.valid = accessDone && !req.isStore;
    assign loadResult.tag  = req.dstTag;
    assign loadResult.data = memRData;

    accessTiming: assert property (
        @(posedge clk) disable iff (rst)
        timerStart |=> (state == ACCESS) [*MemLatency] ##1 (state == FINISH)
    );

    expireInAccess: assert property (
        @(posedge clk) disable iff (rst)
        timerExpired |-> (state == ACCESS)
    );

endmodule

/* rtl/lsUnit.sv */
module lsUnit (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispatchValid,
    input  lsPkg::lsDispatchT dispatch,
    input  lsPkg::resultBusT  aluResult,
    output logic              creditReturn,
    output lsPkg::resultBusT  loadResult
);
    import lsPkg::*;

    logic   issueValid;
    memReqT issueReq;
    logic   ctrlIdle;
    logic   accessDone;
    logic   timerStart;
    logic   timerExpired;
    logic   memWrite;
    addrT   memAddr;
    dataT   memWData;
    dataT   memRData;

    lsQueue uQueue (
        .clk           (clk),
        .rst           (rst),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .aluResult     (aluResult),
        .loadResult    (loadResult),        // Fed back for wakeup
        .ctrlIdle      (ctrlIdle),
        .accessDone    (accessDone),
        .issueValid    (issueValid),
        .issueReq      (issueReq),
        .creditReturn  (creditReturn)
    );

    memCtrl uCtrl (
        .clk          (clk),
        .rst          (rst),
        .issueValid   (issueValid),
        .issueReq     (issueReq),
        .timerExpired (timerExpired),
        .memRData     (memRData),
        .ctrlIdle     (ctrlIdle),
        .accessDone   (accessDone),
        .timerStart   (timerStart),
        .memWrite     (memWrite),
        .memAddr      (memAddr),
        .memWData     (memWData),
        .loadResult   (loadResult)
    );

    accessTimer uTimer (
        .clk     (clk),
        .rst     (rst),
        .start   (timerStart),
        .expired (timerExpired)
    );

    dataMem uMem (
        .clk   (clk),
        .write (memWrite),
        .addr  (memAddr),
        .wData (memWData),
        .rData (memRData)
    );

endmodule

/* verif/lsUnitTb.sv */
module lsUnitTb;
    import lsPkg::*;

    localparam int  RandomCount = 24;
    localparam int  TotalInstrs = LsDepth + 6 + RandomCount;
    localparam int  CycleLimit  = 20 * TotalInstrs + 200;
    localparam int  DrainLimit  = 200;
    localparam tagT AluTag      = 4'hF;                  // Never used as a load tag

    logic       clk;
    logic       rst;
    logic       dispatchValid;
    lsDispatchT dispatch;
    resultBusT  aluResult;
    logic       creditReturn;
    resultBusT  loadResult;

    int          credits;
    int          errors;
    int          cycles;
    int          testsRun;
    int          testsFailed;
    int          testErrors;
    int          expCount;
    logic [31:0] rngState;
    logic [2:0]  tagCount;
    logic        fillPhase;
    logic        holdAlu;
    dataT        model [MemWords];
    addrT        storedAddrs [$];
    resultBusT   expQ [$];
    resultBusT   expHead;

    lsUnit DUT (
        .clk           (clk),
        .rst           (rst),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .aluResult     (aluResult),
        .creditReturn  (creditReturn),
        .loadResult    (loadResult)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // Ready operands with a random base and an imm that lands on address a
    function automatic lsDispatchT makeInstr(logic isStore, addrT a, dataT data);
        lsDispatchT d;
        d.isStore   = isStore;
        d.base      = '{ready: 1'b1, tag: '0, value: nextRand()};
        d.storeData = '{ready: 1'b1, tag: '0, value: data};
        d.imm       = dataT'(a) - d.base.value;
        d.dstTag    = {1'b0, tagCount};
        return d;
    endfunction

    task automatic pushExpected(input tagT tag, input dataT data);
        expQ.push_back('{valid: 1'b1, tag: tag, data: data});
        expCount = expQ.size();
        expHead  = expQ[0];
    endtask

    task automatic sendInstr(input lsDispatchT d);
        while (credits == 0) begin
            @(posedge clk);
            #2;
        end
        dispatchValid = 1'b1;
        dispatch      = d;
        @(posedge clk);
        #2;
        dispatchValid = 1'b0;
    endtask

    task automatic storeWord(input addrT a, input dataT data);
        model[a] = data;
        storedAddrs.push_back(a);
        sendInstr(makeInstr(1'b1, a, data));
    endtask

    task automatic loadWord(input addrT a);
        lsDispatchT d;
        d = makeInstr(1'b0, a, '0);
        pushExpected(d.dstTag, model[a]);
        tagCount = tagCount + 3'd1;
        sendInstr(d);
    endtask

    task automatic waitDrain(input string what);
        int waited;
        waited = 0;
        while ((expCount != 0 || credits != LsDepth) && waited < DrainLimit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (expCount != 0 || credits != LsDepth) begin
            errors++;
            $display("Timeout: %s did not drain, %0d loads missing, %0d credits held",
                     what, expCount, credits);
        end
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (errors != testErrors)
            testsFailed++;
        $display("Test %0d %s: %s", testsRun, name, (errors == testErrors) ? "passed" : "failed");
        testErrors = errors;
    endtask

    // Dispatcher credit model
    always @(posedge clk or posedge rst) begin
        if (rst)
            credits <= LsDepth;
        else
            credits <= credits + (creditReturn ? 1 : 0) - (dispatchValid ? 1 : 0);
    end

    always @(posedge clk) begin
        if (!rst && loadResult.valid && expQ.size() > 0) begin
            void'(expQ.pop_front());
            expCount = expQ.size();
            if (expCount > 0)
                expHead = expQ[0];
        end
    end

    creditRange: assert property (@(negedge clk) disable iff (rst)
        credits >= 0 && credits <= LsDepth)
        else begin
            errors++;
            $display("ERROR credits %h outside 0 to %h", credits, LsDepth);
        end

    quietAtStart: assert property (@(negedge clk)
        (rst || fillPhase) |-> !creditReturn && !loadResult.valid)
        else begin
            errors++;
            $display("ERROR creditReturn %h loadResult.valid %h, expected 0 0",
                     creditReturn, loadResult.valid);
        end

    aluWaitQuiet: assert property (@(negedge clk) disable iff (rst)
        holdAlu |-> !loadResult.valid)
        else begin
            errors++;
            $display("Load completed before its ALU operand was broadcast");
        end

    loadExpected: assert property (@(negedge clk) disable iff (rst)
        loadResult.valid |-> expCount > 0)
        else begin
            errors++;
            $display("Load result with tag %h arrived with no load outstanding", loadResult.tag);
        end

    loadTagMatch: assert property (@(negedge clk) disable iff (rst)
        loadResult.valid && expCount > 0 |-> loadResult.tag == expHead.tag)
        else begin
            errors++;
            $display("ERROR loadResult.tag got %h expected %h", loadResult.tag, expHead.tag);
        end

    loadDataMatch: assert property (@(negedge clk) disable iff (rst)
        loadResult.valid && expCount > 0 |-> loadResult.data == expHead.data)
        else begin
            errors++;
            $display("ERROR loadResult.data got %h expected %h", loadResult.data, expHead.data);
        end

    initial begin
        cycles = 0;
        while (cycles < CycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run exceeded %0d cycles", CycleLimit);
        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors + 1);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        lsDispatchT d;
        dataT       baseVal;
        addrT       a;
        addrT       b;
        tagT        loadTag;
        logic [31:0] r;
        int         idx;
        rst           = 1'b1;
        dispatchValid = 1'b0;
        dispatch      = '0;
        aluResult     = '0;
        rngState      = 32'h55df84e5;
        tagCount      = '0;
        fillPhase     = 1'b0;
        holdAlu       = 1'b0;
        errors        = 0;
        testsRun      = 0;
        testsFailed   = 0;
        testErrors    = 0;
        expCount      = 0;
        expHead       = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        fillPhase = 1'b1;                                // Queue fills before any credit returns
        for (int i = 0; i < LsDepth; i++)
            storeWord(addrT'(nextRand()), nextRand());
        fillPhase = 1'b0;
        waitDrain("reset fill");
        endTest("reset");

        a = addrT'(nextRand());
        storeWord(a, nextRand());
        loadWord(a);
        waitDrain("store then load");
        endTest("store then load");

        d            = makeInstr(1'b0, a, '0);
        baseVal      = d.base.value;
        d.base.ready = 1'b0;
        d.base.tag   = AluTag;
        d.base.value = ~baseVal;                         // Stale value the broadcast replaces
        pushExpected(d.dstTag, model[a]);
        tagCount = tagCount + 3'd1;
        holdAlu  = 1'b1;
        sendInstr(d);
        repeat (8) begin
            @(posedge clk);
            #2;
        end
        holdAlu   = 1'b0;
        aluResult = '{valid: 1'b1, tag: AluTag, data: baseVal};
        @(posedge clk);
        #2;
        aluResult = '0;
        waitDrain("ALU wakeup");
        endTest("ALU wakeup");

        b       = addrT'(nextRand());
        loadTag = {1'b0, tagCount};
        loadWord(a);
        d                 = makeInstr(1'b1, b, nextRand());
        d.storeData.ready = 1'b0;
        d.storeData.tag   = loadTag;                     // Data comes from the load above
        model[b]          = model[a];
        storedAddrs.push_back(b);
        sendInstr(d);
        loadWord(b);
        waitDrain("load-result wakeup");
        endTest("load-result wakeup");

        for (int i = 0; i < RandomCount; i++) begin
            r = nextRand();
            if (r[0]) begin
                idx = int'(r[16:1]) % storedAddrs.size();
                loadWord(storedAddrs[idx]);
            end else begin
                storeWord(addrT'(nextRand()), nextRand());
            end
        end
        waitDrain("random traffic");
        endTest("random traffic");

        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* build.f */
rtl/lsPkg.sv
rtl/accessTimer.sv
rtl/dataMem.sv
rtl/lsEntry.sv
rtl/lsQueue.sv
rtl/memCtrl.sv
rtl/lsUnit.sv
verif/lsUnitTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module lsUnitTb -o lsUnitSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/lsUnitSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "Simulation reported failures"
exit 1
